// File: cam_cases.txt
# cmd_byte(hex) cmd_len when frames expected_packets
# cmd_len 0 sends no command; when 1 sends it after line 1 of the first frame
00 0 0 1 0
31 1 0 2 8
30 2 0 1 4
41 1 0 1 4
30 1 1 1 4
00 0 0 1 0
31 2 0 1 0
55 1 0 1 0
31 1 1 1 0
00 0 0 1 4
30 1 0 2 0

// File: compile.f
+incdir+.
cam_udp_pkg.sv
tx_stream_if.sv
start_transfer_ctrl.sv
pkt_fifo.sv
img_data_pkt.sv
udp_tx_stream.sv
cam_udp_top.sv
tb_cam_udp.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the camera UDP testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module tb_cam_udp -o sim_tb_cam_udp
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb_cam_udp 2>&1)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

// File: tb_cam_udp.sv
// Camera UDP streamer testbench
`timescale 1ns/1ps
`include "cam_udp_defines.svh"

module tb_cam_udp;

    localparam int BLANK_CYCLES = 40;  // Idle after each line, longer than one packet
    localparam int VSYNC_CYCLES = 8;   // Covers the four magic writes
    localparam int FRAME_CYCLES = VSYNC_CYCLES + `CAM_LINES * (`CAM_LINE_BYTES + 1 + BLANK_CYCLES);
    localparam int CASE_SLACK   = 200; // Command packets and drain per case
    localparam int DRAIN_CYCLES = 100;
    localparam logic [15:0] SRC_PORT = `UDP_SRC_PORT;
    localparam logic [15:0] DST_PORT = `UDP_DST_PORT;
    localparam logic [31:0] MAGIC    = `FRAME_MAGIC;

    logic        sys_clk;
    logic        reset;
    logic        cam_vsync;
    logic        cam_href;
    logic [7:0]  cam_data;
    logic        rec_en;
    logic [7:0]  rec_data;
    logic        rec_pkt_done;
    logic [15:0] rec_byte_num;
    logic        udp_valid;
    logic [7:0]  udp_data;
    logic        udp_last;
    logic        transfer_flag;

    // Case table from cam_cases.txt
    logic [7:0] case_cmd [$];
    int         case_len [$];
    int         case_when [$];  // 0 before the frames, 1 inside the first frame
    int         case_frames [$];
    int         case_pkts [$];

    logic [8:0] exp_q [$];      // {last, byte} in output order
    bit         model_flag;     // Reference copy of the transfer flag
    bit         in_pkt;         // Between first and last byte of a packet
    int         pkt_seen;
    integer     seed;
    bit         cases_loaded;
    int         limit_cycles;

    cam_udp_top cam_udp_top_i (
        .sys_clk       (sys_clk),
        .reset         (reset),
        .cam_vsync     (cam_vsync),
        .cam_href      (cam_href),
        .cam_data      (cam_data),
        .rec_en        (rec_en),
        .rec_data      (rec_data),
        .rec_pkt_done  (rec_pkt_done),
        .rec_byte_num  (rec_byte_num),
        .udp_valid     (udp_valid),
        .udp_data      (udp_data),
        .udp_last      (udp_last),
        .transfer_flag (transfer_flag)
    );

    initial sys_clk = 1'b0;
    always #5 sys_clk = ~sys_clk;  // 100 MHz

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "Run stopped at %0t ns", $time);
    endtask

    task automatic push_byte(input logic [7:0] b, input logic last);
        exp_q.push_back({last, b});
    endtask

    // UDP header, every field high byte first
    task automatic push_udp_header(input logic [15:0] pay_len);
        logic [15:0] udp_len;
        udp_len = pay_len + 16'(`UDP_HDR_BYTES);
        push_byte(SRC_PORT[15:8], 1'b0);
        push_byte(SRC_PORT[7:0], 1'b0);
        push_byte(DST_PORT[15:8], 1'b0);
        push_byte(DST_PORT[7:0], 1'b0);
        push_byte(udp_len[15:8], 1'b0);
        push_byte(udp_len[7:0], 1'b0);
        push_byte(8'h00, 1'b0);  // Checksum
        push_byte(8'h00, 1'b0);
    endtask

    // -------------------------------------------------------------------
    // Host command packets
    // -------------------------------------------------------------------
    task automatic send_command(input logic [7:0] cmd, input int len);
        int i;
        for (i = 0; i < len; i++) begin
            @(posedge sys_clk);
            #1;
            rec_en   = 1'b1;
            rec_data = (i == 0) ? cmd : 8'h20;  // Pad after byte 0
        end
        @(posedge sys_clk);
        #1;
        rec_en       = 1'b0;
        rec_pkt_done = 1'b1;
        rec_byte_num = 16'(len);
        @(posedge sys_clk);
        #1;
        rec_pkt_done = 1'b0;
        // Only single-byte start or stop packets move the flag
        if (len == 1 && cmd == cam_udp_pkg::CMD_START)
            model_flag = 1'b1;
        else if (len == 1 && cmd == cam_udp_pkg::CMD_STOP)
            model_flag = 1'b0;
        @(negedge sys_clk);
        assert (transfer_flag == model_flag) else begin
            $display("** Error at %0t ns: transfer_flag = %b, expected %b",
                     $time, transfer_flag, model_flag);
            abort_run();
        end
    endtask

    // -------------------------------------------------------------------
    // Camera model, one frame with optional command after line 1
    // -------------------------------------------------------------------
    task automatic send_frame(input bit mid_cmd, input logic [7:0] cmd, input int len);
        logic [7:0]  pix;
        logic [15:0] pay_len;
        bit          active;
        int          ln;
        int          i;
        @(posedge sys_clk);
        #1;
        cam_vsync = 1'b1;
        active    = model_flag;  // Flag as seen at the vsync edge
        repeat (VSYNC_CYCLES) @(posedge sys_clk);
        #1;
        cam_vsync = 1'b0;
        for (ln = 0; ln < `CAM_LINES; ln++) begin
            pay_len = (ln == 0) ? 16'(`CAM_LINE_BYTES + `FRAME_HDR_BYTES)
                                : 16'(`CAM_LINE_BYTES);
            if (active) begin
                push_udp_header(pay_len);
                if (ln == 0) begin
                    for (i = 3; i >= 0; i--)
                        push_byte(MAGIC[i*8 +: 8], 1'b0);  // Magic, top byte first
                end
            end
            for (i = 0; i < `CAM_LINE_BYTES; i++) begin
                pix = 8'($random(seed));
                if (active)
                    push_byte(pix, i == `CAM_LINE_BYTES - 1);
                @(posedge sys_clk);
                #1;
                cam_href = 1'b1;
                cam_data = pix;
            end
            @(posedge sys_clk);
            #1;
            cam_href = 1'b0;
            cam_data = 8'h00;
            repeat (BLANK_CYCLES) @(posedge sys_clk);
            if (mid_cmd && ln == 1)
                send_command(cmd, len);
        end
    endtask

    task automatic wait_drain();
        int w;
        w = 0;
        while (exp_q.size() != 0 && w < DRAIN_CYCLES) begin
            @(posedge sys_clk);
            w++;
        end
        assert (exp_q.size() == 0) else begin
            $display("Expected UDP bytes did not arrive within %0d cycles", DRAIN_CYCLES);
            abort_run();
        end
    endtask

    task automatic load_cases();
        int         fd;
        int         n;
        int         total_frames;
        string      line;
        logic [7:0] cb;
        int         cl;
        int         wh;
        int         fr;
        int         ep;
        total_frames = 0;
        fd = $fopen("cam_cases.txt", "r");
        assert (fd != 0) else begin
            $display("Cannot open cam_cases.txt");
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#") begin  // Skip column notes
                n = $sscanf(line, "%h %d %d %d %d", cb, cl, wh, fr, ep);
                if (n == 5) begin
                    case_cmd.push_back(cb);
                    case_len.push_back(cl);
                    case_when.push_back(wh);
                    case_frames.push_back(fr);
                    case_pkts.push_back(ep);
                    total_frames += fr;
                end
            end
        end
        $fclose(fd);
        assert (case_cmd.size() != 0) else begin
            $display("No test cases found in cam_cases.txt");
            abort_run();
        end
        limit_cycles = total_frames * FRAME_CYCLES + case_cmd.size() * CASE_SLACK + 100;
        cases_loaded = 1'b1;
    endtask

    // Output monitor, sampled mid-cycle
    always @(negedge sys_clk) begin
        logic [8:0] exp;
        if (!reset && in_pkt) begin
            assert (udp_valid == 1'b1) else begin  // No gap inside a packet
                $display("** Error at %0t ns: udp_valid = %b, expected 1",
                         $time, udp_valid);
                abort_run();
            end
        end
        if (!reset && udp_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("Unexpected UDP byte 0x%02h at %0t ns, no packet was due",
                         udp_data, $time);
                abort_run();
            end
            exp = exp_q.pop_front();
            assert (udp_data == exp[7:0]) else begin
                $display("** Error at %0t ns: udp_data = 0x%02h, expected 0x%02h",
                         $time, udp_data, exp[7:0]);
                abort_run();
            end
            assert (udp_last == exp[8]) else begin
                $display("** Error at %0t ns: udp_last = %b, expected %b",
                         $time, udp_last, exp[8]);
                abort_run();
            end
            if (udp_last)
                pkt_seen++;
            in_pkt = !udp_last;
        end
    end

    // Watchdog sized from the frame count in the case file
    initial begin
        wait (cases_loaded);
        repeat (limit_cycles) @(posedge sys_clk);
        $display("Timeout: run did not finish within %0d clock cycles", limit_cycles);
        abort_run();
    end

    // -------------------------------------------------------------------
    // Main sequence
    // -------------------------------------------------------------------
    initial begin
        int c;
        int f;
        int start_cnt;
        reset        = 1'b1;
        cam_vsync    = 1'b0;
        cam_href     = 1'b0;
        cam_data     = 8'h00;
        rec_en       = 1'b0;
        rec_data     = 8'h00;
        rec_pkt_done = 1'b0;
        rec_byte_num = 16'd0;
        model_flag   = 1'b0;
        in_pkt       = 1'b0;
        pkt_seen     = 0;
        seed         = 34;
        cases_loaded = 1'b0;
        load_cases();
        repeat (2) @(posedge sys_clk);
        #1;
        reset = 1'b0;
        @(negedge sys_clk);
        assert (udp_valid == 1'b0) else begin
            $display("** Error at %0t ns: udp_valid = %b, expected 0", $time, udp_valid);
            abort_run();
        end
        assert (transfer_flag == 1'b0) else begin
            $display("** Error at %0t ns: transfer_flag = %b, expected 0",
                     $time, transfer_flag);
            abort_run();
        end
        for (c = 0; c < case_cmd.size(); c++) begin
            start_cnt = pkt_seen;
            if (case_len[c] != 0 && case_when[c] == 0)
                send_command(case_cmd[c], case_len[c]);
            for (f = 0; f < case_frames[c]; f++)
                send_frame(case_len[c] != 0 && case_when[c] != 0 && f == 0,
                           case_cmd[c], case_len[c]);
            wait_drain();
            assert (pkt_seen - start_cnt == case_pkts[c]) else begin
                $display("** Error at %0t ns: packet count = %0d, expected %0d (case %0d)",
                         $time, pkt_seen - start_cnt, case_pkts[c], c);
                abort_run();
            end
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: cam_udp_top.sv
// Camera to UDP streaming top
`timescale 1ns/1ps

module cam_udp_top (
    input  logic                  sys_clk,
    input  logic                  reset,
    // Camera
    input  logic                  cam_vsync,
    input  logic                  cam_href,
    input  logic [7:0]            cam_data,
    // UDP receive payload
    input  logic                  rec_en,
    input  logic [7:0]            rec_data,
    input  logic                  rec_pkt_done,
    input  cam_udp_pkg::pkt_len_t rec_byte_num,
    // UDP transmit byte stream
    output logic                  udp_valid,
    output logic [7:0]            udp_data,
    output logic                  udp_last,
    output logic                  transfer_flag  // Host has asked for frames
);

    tx_stream_if tx_if ();   // Packer to streamer

    // Host command decode
    start_transfer_ctrl u_start_transfer_ctrl (
        .clk           (sys_clk),
        .reset         (reset),
        .rec_en        (rec_en),
        .rec_data      (rec_data),
        .rec_pkt_done  (rec_pkt_done),
        .rec_byte_num  (rec_byte_num),
        .transfer_flag (transfer_flag)
    );

    // Line packing and FIFO
    img_data_pkt u_img_data_pkt (
        .clk           (sys_clk),
        .reset         (reset),
        .cam_vsync     (cam_vsync),
        .cam_href      (cam_href),
        .cam_data      (cam_data),
        .transfer_flag (transfer_flag),
        .tx            (tx_if.pkt_side)
    );

    // UDP framing
    udp_tx_stream u_udp_tx_stream (
        .clk       (sys_clk),
        .reset     (reset),
        .tx        (tx_if.udp_side),
        .udp_valid (udp_valid),
        .udp_data  (udp_data),
        .udp_last  (udp_last)
    );

endmodule

// File: udp_tx_stream.sv
// UDP header and payload streamer
`timescale 1ns/1ps
`include "cam_udp_defines.svh"

module udp_tx_stream (
    input  logic          clk,
    input  logic          reset,
    tx_stream_if.udp_side tx,
    output logic          udp_valid,
    output logic [7:0]    udp_data,
    output logic          udp_last   // With the final payload byte
);

    localparam logic [15:0] SRC_PORT = `UDP_SRC_PORT;
    localparam logic [15:0] DST_PORT = `UDP_DST_PORT;
    localparam logic [2:0]  HDR_LAST = 3'(`UDP_HDR_BYTES - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_PAYLOAD
    } state_e;

    state_e                state;
    cam_udp_pkg::pkt_len_t byte_cnt; // Header index, then payload index
    cam_udp_pkg::pkt_len_t pay_len;  // Latched at start_en
    cam_udp_pkg::pkt_len_t udp_len;  // Length field, header included
    logic [7:0]            hdr_byte;
    logic                  hdr_last;
    logic                  pay_last;

    assign udp_len  = pay_len + 16'(`UDP_HDR_BYTES);
    assign hdr_last = (state == ST_HEADER) && (byte_cnt[2:0] == HDR_LAST);
    assign pay_last = (state == ST_PAYLOAD) && (byte_cnt == pay_len - 16'd1);

    // Header field select, high byte first
    always_comb begin
        case (byte_cnt[2:0])
            3'd0:    hdr_byte = SRC_PORT[15:8];
            3'd1:    hdr_byte = SRC_PORT[7:0];
            3'd2:    hdr_byte = DST_PORT[15:8];
            3'd3:    hdr_byte = DST_PORT[7:0];
            3'd4:    hdr_byte = udp_len[15:8];
            3'd5:    hdr_byte = udp_len[7:0];
            default: hdr_byte = 8'h00;       // Checksum left at zero
        endcase
    end

    // Fetch one ahead so the registered FIFO byte meets its slot
    assign tx.req = hdr_last ||
                    ((state == ST_PAYLOAD) && (byte_cnt + 16'd1 < pay_len));

    assign udp_valid = (state != ST_IDLE);
    assign udp_data  = (state == ST_PAYLOAD) ? tx.data : hdr_byte;
    assign udp_last  = pay_last;

    // -------------------------------------------------------------------
    // Packet FSM
    // -------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            byte_cnt <= '0;
            tx.done  <= 1'b0;
        end else begin
            tx.done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (tx.start_en) begin
                        state    <= ST_HEADER;
                        byte_cnt <= '0;
                    end
                end
                ST_HEADER: begin
                    if (hdr_last) begin
                        state    <= ST_PAYLOAD;
                        byte_cnt <= '0;      // Restart for payload
                    end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                ST_PAYLOAD: begin
                    if (pay_last) begin
                        state   <= ST_IDLE;
                        tx.done <= 1'b1;     // Pulse after last byte
                    end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && tx.start_en)
            pay_len <= tx.byte_num;
    end

    // Packer must wait for done before the next request
    a_start_when_idle: assert property (
        @(posedge clk) disable iff (reset) tx.start_en |-> (state == ST_IDLE)
    );

endmodule

// File: img_data_pkt.sv
// Camera line packer with frame gating
`timescale 1ns/1ps
`include "cam_udp_defines.svh"

module img_data_pkt (
    input  logic          clk,
    input  logic          reset,
    input  logic          cam_vsync,
    input  logic          cam_href,      // Line valid, one byte per cycle
    input  logic [7:0]    cam_data,
    input  logic          transfer_flag, // Sampled at frame start only
    tx_stream_if.pkt_side tx
);

    localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);
    localparam cam_udp_pkg::pkt_len_t LINE_LEN  = `CAM_LINE_BYTES;
    localparam cam_udp_pkg::pkt_len_t FIRST_LEN = `CAM_LINE_BYTES + `FRAME_HDR_BYTES;

    logic                  vsync_d;
    logic                  href_d;
    logic                  vsync_rise;   // Frame start
    logic                  href_fall;    // Line end
    logic                  frame_active; // Current frame is being sent
    logic [2:0]            hdr_cnt;      // Magic bytes still to write
    logic [31:0]           hdr_shift;
    logic [15:0]           line_cnt;     // Lines done in this frame
    logic [15:0]           href_cnt;     // href cycles in current line
    logic                  first_line;
    cam_udp_pkg::pkt_len_t line_len;
    logic                  tx_busy;      // Streamer owns a packet
    logic                  start_go;
    logic                  fifo_wr;
    logic [7:0]            fifo_wr_data;
    logic [CNT_W-1:0]      fifo_count;
    logic                  fifo_empty;

    // -------------------------------------------------------------------
    // Edge detect and write path
    // -------------------------------------------------------------------
    assign vsync_rise = cam_vsync & ~vsync_d;
    assign href_fall  = ~cam_href & href_d;
    assign first_line = (line_cnt == '0);
    assign line_len   = first_line ? FIRST_LEN : LINE_LEN; // Line 0 carries magic too

    // Header bytes first, then camera bytes of gated frames
    assign fifo_wr      = (hdr_cnt != 3'd0) | (cam_href & frame_active);
    assign fifo_wr_data = (hdr_cnt != 3'd0) ? hdr_shift[31:24] : cam_data;

    // Whole line buffered and streamer free
    assign start_go = href_fall & frame_active & ~tx_busy &
                      (cam_udp_pkg::pkt_len_t'(fifo_count) >= line_len);

    always_ff @(posedge clk) begin
        if (reset) begin
            vsync_d      <= 1'b0;
            href_d       <= 1'b0;
            frame_active <= 1'b0;
            hdr_cnt      <= 3'd0;
            line_cnt     <= '0;
            href_cnt     <= '0;
            tx_busy      <= 1'b0;
            tx.start_en  <= 1'b0;
        end else begin
            vsync_d     <= cam_vsync;
            href_d      <= cam_href;
            href_cnt    <= cam_href ? href_cnt + 1'b1 : '0;
            tx.start_en <= start_go;                 // One cycle after line end

            if (vsync_rise) begin
                frame_active <= transfer_flag;       // Gate the whole frame
                line_cnt     <= '0;
            end else if (href_fall && frame_active) begin
                line_cnt <= line_cnt + 1'b1;
            end

            if (vsync_rise && transfer_flag)
                hdr_cnt <= 3'(`FRAME_HDR_BYTES);
            else if (hdr_cnt != 3'd0)
                hdr_cnt <= hdr_cnt - 1'b1;

            if (start_go)
                tx_busy <= 1'b1;
            else if (tx.done)
                tx_busy <= 1'b0;
        end
    end

    // Magic shifter and packet length
    always_ff @(posedge clk) begin
        if (vsync_rise)
            hdr_shift <= `FRAME_MAGIC;
        else if (hdr_cnt != 3'd0)
            hdr_shift <= {hdr_shift[23:0], 8'h00};   // Next byte to top
        if (start_go)
            tx.byte_num <= line_len;
    end

    pkt_fifo #(
        .DEPTH (`FIFO_DEPTH)
    ) u_pkt_fifo (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (fifo_wr),
        .wr_data (fifo_wr_data),
        .rd_en   (tx.req),
        .rd_data (tx.data),
        .empty   (fifo_empty),
        .count   (fifo_count)
    );

    // -------------------------------------------------------------------
    // Checks on camera timing
    // -------------------------------------------------------------------
    a_line_bytes: assert property (
        @(posedge clk) disable iff (reset)
        (href_fall && frame_active) |-> (href_cnt == 16'(`CAM_LINE_BYTES))
    );
    a_frame_lines: assert property (
        @(posedge clk) disable iff (reset)
        (vsync_rise && frame_active) |-> (line_cnt == 16'(`CAM_LINES))
    );
    // Previous frame fully drained before new magic goes in
    a_frame_drained: assert property (
        @(posedge clk) disable iff (reset)
        (vsync_rise && transfer_flag) |-> fifo_empty
    );

endmodule

// File: pkt_fifo.sv
// Byte FIFO for packet payloads
`timescale 1ns/1ps

module pkt_fifo #(
    parameter int DEPTH = 64
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         wr_en,
    input  logic [7:0]                   wr_data,
    input  logic                         rd_en,
    output logic [7:0]                   rd_data, // Registered, valid one cycle after rd_en
    output logic                         empty,
    output logic [$clog2(DEPTH+1)-1:0]   count    // Bytes held
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    logic [7:0]    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          full;
    logic          do_wr;
    logic          do_rd;

    assign full  = (count == CW'(DEPTH));
    assign empty = (count == '0);
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // Storage and registered read port
    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
        if (do_rd)
            rd_data <= mem[rd_ptr];
    end

    // -------------------------------------------------------------------
    // Pointers and occupancy
    // -------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // Wrap
            if (do_rd)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // Idle or write plus read
            endcase
        end
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (reset) !(wr_en && full)
    );
    a_no_underflow: assert property (
        @(posedge clk) disable iff (reset) !(rd_en && empty)
    );

endmodule

// File: start_transfer_ctrl.sv
// Host start and stop command decoder
`timescale 1ns/1ps

module start_transfer_ctrl (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rec_en,        // Received payload byte strobe
    input  logic [7:0]            rec_data,
    input  logic                  rec_pkt_done,  // End of received packet
    input  cam_udp_pkg::pkt_len_t rec_byte_num,  // Payload length of that packet
    output logic                  transfer_flag  // High while frames are wanted
);

    logic                   first_byte; // Next rec_en carries payload byte 0
    cam_udp_pkg::ctrl_cmd_e cmd_byte;   // Payload byte 0 of the current packet

    // -------------------------------------------------------------------
    // Packet tracking and flag update
    // -------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            first_byte    <= 1'b1;
            transfer_flag <= 1'b0;
        end else begin
            if (rec_en && first_byte)
                first_byte <= 1'b0;
            if (rec_pkt_done) begin
                first_byte <= 1'b1;                 // Rearm for next packet
                if (rec_byte_num == 16'd1) begin    // Only one-byte commands count
                    case (cmd_byte)
                        cam_udp_pkg::CMD_START: transfer_flag <= 1'b1;
                        cam_udp_pkg::CMD_STOP:  transfer_flag <= 1'b0;
                        default:                transfer_flag <= transfer_flag;
                    endcase
                end
            end
        end
    end

    // Command byte capture
    always_ff @(posedge clk) begin
        if (rec_en && first_byte)
            cmd_byte <= cam_udp_pkg::ctrl_cmd_e'(rec_data);
    end

    // MAC never flags a byte and packet end together
    a_no_done_with_byte: assert property (
        @(posedge clk) disable iff (reset) !(rec_en && rec_pkt_done)
    );

endmodule

// File: tx_stream_if.sv
// Packer to UDP streamer link
`timescale 1ns/1ps

interface tx_stream_if;

    logic                  start_en; // One-cycle packet request
    cam_udp_pkg::pkt_len_t byte_num; // Payload length, valid with start_en
    logic [7:0]            data;     // FIFO read data, one cycle after req
    logic                  req;      // Pull one payload byte
    logic                  done;     // Pulse after the last payload byte

    // Packer side owns the FIFO and the request
    modport pkt_side (
        output start_en,
        output byte_num,
        output data,
        input  req,
        input  done
    );

    // Streamer side pulls bytes and reports completion
    modport udp_side (
        input  start_en,
        input  byte_num,
        input  data,
        output req,
        output done
    );

endinterface

// File: cam_udp_pkg.sv
// Camera UDP shared types
`include "cam_udp_defines.svh"

package cam_udp_pkg;

    // Byte count of a UDP payload or a received packet
    typedef logic [15:0] pkt_len_t;

    // Single-byte host command
    typedef enum logic [7:0] {
        CMD_START = `CMD_START_BYTE, // Begin sending frames
        CMD_STOP  = `CMD_STOP_BYTE   // Stop after the current frame
    } ctrl_cmd_e;

endpackage

// File: cam_udp_defines.svh
// Camera UDP streaming constants
`ifndef CAM_UDP_DEFINES_SVH
`define CAM_UDP_DEFINES_SVH

// Frame geometry, reduced from the 1280-byte sensor line
`define CAM_LINE_BYTES   16
`define CAM_LINES        4

// Packet payload buffer
`define FIFO_DEPTH       64

// UDP header fields
`define UDP_SRC_PORT     16'd1234
`define UDP_DST_PORT     16'd1234
`define UDP_HDR_BYTES    8

// Frame header in front of line 0, MSB byte goes out first
`define FRAME_MAGIC      32'hF05A_A50F
`define FRAME_HDR_BYTES  4

// Host commands, ASCII '1' and '0'
`define CMD_START_BYTE   8'h31
`define CMD_STOP_BYTE    8'h30

`endif
